/* filelist.f */
logic/ksPkg.sv
logic/consoleCtl.sv
logic/intervalTimer.sv
logic/intrArbiter.sv
logic/busCycle.sv
logic/cpuSupport.sv
sim/cpuSupportTb.sv

/* sim/cpuSupportTb.sv */
/*
 * Testbench for the KS10 CPU support logic
 * Applies a table of console, interrupt line and timer settings, answers
 * acknowledge cycles with random delays and checks levels, vectors and
 * the timer count against the interrupt rules.
 */

`timescale 1ns/1ps
`default_nettype none

module cpuSupportTb;

   // Row columns are run, halt, lines raised, timer window, expected level and dismiss
   typedef struct packed {
      logic             run;
      logic             halt;
      ksPkg::intrLinesT lines;
      logic             timerEn;
      ksPkg::intpT      expLevel;
      logic             dismiss;
   } rowT;

   localparam int numRows       = 13;
   localparam int timerTicks    = 3;
   localparam int quietCycles   = 30;
   localparam int timeoutCycles = numRows * 200;

   logic               clk;
   logic               rst;
   logic               cslRUN;
   logic               cslHALT;
   logic               cslTIMEREN;
   logic               intrDismiss;
   logic               busACK;
   ksPkg::intrLinesT   busINTR;
   ksPkg::wordT        busDATAI;
   logic               cpuHALT;
   logic               busREQ;
   ksPkg::busAddrT     busADDRO;
   ksPkg::intpT        curINTP;
   ksPkg::wordT        intrVector;
   ksPkg::timerCountT  timerCOUNT;

   rowT         rows [numRows];
   ksPkg::intpT ackedLevel;           // Last level seen on the bus
   logic        expHalted;
   logic [31:0] lfsr = 32'hdec9;
   int          checks = 0;
   int          errors = 0;

   cpuSupport dut0 (
      .clk         (clk),
      .rst         (rst),
      .cslRUN      (cslRUN),
      .cslHALT     (cslHALT),
      .cslTIMEREN  (cslTIMEREN),
      .busINTR     (busINTR),
      .intrDismiss (intrDismiss),
      .busACK      (busACK),
      .busDATAI    (busDATAI),
      .cpuHALT     (cpuHALT),
      .busREQ      (busREQ),
      .busADDRO    (busADDRO),
      .curINTP     (curINTP),
      .intrVector  (intrVector),
      .timerCOUNT  (timerCOUNT)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////
   // Helpers and compare tasks

   // Fibonacci LFSR with taps 32, 22, 2, 1
   function automatic int takeBits(input int n);
      int value;
      value = 0;
      for (int i = 0; i < n; i++) begin
         lfsr  = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         value = (value << 1) | lfsr[0];
      end
      return value;
   endfunction

   function automatic ksPkg::wordT expectedVector(input ksPkg::intpT level);
      return ksPkg::wordT'(36'o100 + 4 * level);   // Octal 100 plus 4 per level
   endfunction

   task automatic checkBit(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic checkLevel(input ksPkg::intpT got, input ksPkg::intpT exp,
                             input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic checkWord(input ksPkg::wordT got, input ksPkg::wordT exp,
                            input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s is %o, expected %o", $time, what, got, exp);
      end
   endtask

   task automatic checkCount(input ksPkg::timerCountT got, input ksPkg::timerCountT exp,
                             input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   //////////////////////////////
   // Bus responder

   initial begin : responder
      ksPkg::busAddrT addr;
      int             delay;
      busACK     = 1'b0;
      busDATAI   = '0;
      ackedLevel = '0;
      forever begin
         @(negedge clk);
         if (busREQ && !busACK) begin
            addr       = busADDRO;
            ackedLevel = addr.level;
            checkBit(addr.ackCycle, 1'b1, "busADDRO.ackCycle");
            delay = takeBits(2);
            repeat (delay) begin
               @(negedge clk);
               checkBit(busREQ, 1'b1, "busREQ before busACK");
               checkLevel(busADDRO.level, addr.level, "busADDRO.level under busREQ");
            end
            busDATAI = expectedVector(addr.level);
            busACK   = 1'b1;
            busINTR[addr.level] = 1'b0;          // Device drops its line
            delay = takeBits(2);
            @(negedge clk);
            checkBit(busREQ, 1'b0, "busREQ after busACK");
            repeat (delay) begin
               @(negedge clk);
               checkBit(busREQ, 1'b0, "busREQ while busACK high");
            end
            busACK = 1'b0;
         end
      end
   end

   //////////////////////////////
   // Table rows

   task automatic applyRow(input int r);
      rowT               row;
      ksPkg::timerCountT startCount;
      row = rows[r];
      @(negedge clk);
      cslRUN  = row.run;
      cslHALT = row.halt;
      busINTR = busINTR | row.lines;
      if (row.halt)
         expHalted = 1'b1;
      else if (row.run)
         expHalted = 1'b0;
      @(negedge clk);
      cslRUN  = 1'b0;
      cslHALT = 1'b0;
      checkBit(cpuHALT, expHalted, "cpuHALT");
      if (row.timerEn) begin
         startCount = timerCOUNT;
         cslTIMEREN = 1'b1;
         repeat (timerTicks * ksPkg::msecTicks) @(negedge clk);
         cslTIMEREN = 1'b0;
         startCount = ksPkg::timerCountT'(startCount + timerTicks);
         checkCount(timerCOUNT, startCount, "timerCOUNT after enable");
         repeat (quietCycles) @(negedge clk);
         checkCount(timerCOUNT, startCount, "timerCOUNT while disabled");
      end
      if (row.expLevel == '0) begin
         repeat (quietCycles) begin
            @(negedge clk);
            checkBit(busREQ, 1'b0, "busREQ while blocked");
         end
      end else begin
         while (curINTP == '0)
            @(negedge clk);                      // Wait for the grant
         checkLevel(curINTP, row.expLevel, "curINTP");
         checkLevel(ackedLevel, row.expLevel, "acknowledged level");
         checkWord(intrVector, expectedVector(row.expLevel), "intrVector");
      end
      if (row.dismiss) begin
         @(negedge clk);
         intrDismiss = 1'b1;
         @(negedge clk);
         intrDismiss = 1'b0;
         checkLevel(curINTP, '0, "curINTP after dismiss");
      end
      $display("Row %0d done, %0d errors so far", r, errors);
   endtask

   initial begin
      rst         = 1'b1;
      cslRUN      = 1'b0;
      cslHALT     = 1'b0;
      cslTIMEREN  = 1'b0;
      intrDismiss = 1'b0;
      busINTR     = '0;
      expHalted   = 1'b1;
      // run, halt, lines [7:1], timer, level, dismiss
      rows[0]  = {1'b0, 1'b0, 7'b0000110, 1'b0, 3'd0, 1'b0};   // Halted so no cycle
      rows[1]  = {1'b1, 1'b0, 7'b0000000, 1'b0, 3'd2, 1'b0};
      rows[2]  = {1'b0, 1'b0, 7'b0000001, 1'b0, 3'd0, 1'b1};   // Level 2 blocks line 1
      rows[3]  = {1'b0, 1'b0, 7'b0000000, 1'b0, 3'd1, 1'b1};
      rows[4]  = {1'b0, 1'b0, 7'b0000000, 1'b0, 3'd3, 1'b0};
      rows[5]  = {1'b0, 1'b1, 7'b1000000, 1'b0, 3'd0, 1'b1};
      rows[6]  = {1'b0, 1'b0, 7'b0000000, 1'b0, 3'd0, 1'b0};   // Still halted
      rows[7]  = {1'b1, 1'b0, 7'b0000000, 1'b0, 3'd7, 1'b1};
      rows[8]  = {1'b0, 1'b0, 7'b0000000, 1'b1, 3'd3, 1'b1};   // Timer window
      rows[9]  = {1'b0, 1'b0, 7'b0000000, 1'b0, 3'd3, 1'b1};   // Later tick re-requests
      rows[10] = {1'b0, 1'b0, 7'b0101010, 1'b0, 3'd2, 1'b1};
      rows[11] = {1'b0, 1'b0, 7'b0000000, 1'b0, 3'd4, 1'b1};
      rows[12] = {1'b0, 1'b0, 7'b0000000, 1'b0, 3'd6, 1'b1};
      repeat (8) @(negedge clk);
      rst = 1'b0;
      checkBit(cpuHALT, 1'b1, "cpuHALT after reset");
      checkBit(busREQ, 1'b0, "busREQ after reset");
      checkBit(busADDRO.ackCycle, 1'b0, "busADDRO.ackCycle after reset");
      checkLevel(busADDRO.level, '0, "busADDRO.level after reset");
      checkLevel(curINTP, '0, "curINTP after reset");
      checkWord(intrVector, '0, "intrVector after reset");
      checkCount(timerCOUNT, '0, "timerCOUNT after reset");
      $display("Reset test done, %0d errors so far", errors);
      for (int r = 0; r < numRows; r++)
         applyRow(r);
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < timeoutCycles) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d cycles, a bus cycle or grant never completed", cycles);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

/* logic/cpuSupport.sv */
/*
 * KS10 CPU support logic, top level
 * Console run/halt control, interval timer, priority interrupt
 * controller and the interrupt acknowledge bus cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module cpuSupport (
   input  wire                    clk,
   input  wire                    rst,
   input  wire                    cslRUN,       // Run switch
   input  wire                    cslHALT,      // Halt switch
   input  wire                    cslTIMEREN,   // Timer enable
   input  wire ksPkg::intrLinesT  busINTR,      // Bus interrupt lines
   input  wire                    intrDismiss,  // End of service
   input  wire                    busACK,       // Bus acknowledge
   input  wire ksPkg::wordT       busDATAI,     // Bus data input
   output logic                   cpuHALT,      // Run/halt status
   output logic                   busREQ,       // Bus request
   output ksPkg::busAddrT         busADDRO,     // Bus address and flags
   output ksPkg::intpT            curINTP,      // Level in service
   output ksPkg::wordT            intrVector,   // Last vector word
   output ksPkg::timerCountT      timerCOUNT    // Interval count
);

   logic           cpuRun;
   logic           timerINTR;
   ksPkg::intrReqT request;
   ksPkg::grantT   grant;

   consoleCtl uConsole (
      .clk        (clk),
      .rst        (rst),
      .cslRUN     (cslRUN),
      .cslHALT    (cslHALT),
      .cpuRun     (cpuRun),
      .cpuHALT    (cpuHALT)
   );

   intervalTimer uTimer (
      .clk        (clk),
      .rst        (rst),
      .timerEN    (cslTIMEREN),
      .grant      (grant),
      .timerINTR  (timerINTR),
      .timerCOUNT (timerCOUNT)
   );

   intrArbiter uArbiter (
      .clk         (clk),
      .rst         (rst),
      .busINTR     (busINTR),
      .timerINTR   (timerINTR),
      .intrDismiss (intrDismiss),
      .grant       (grant),
      .request     (request),
      .curINTP     (curINTP)
   );

   busCycle uBus (
      .clk        (clk),
      .rst        (rst),
      .cpuRun     (cpuRun),
      .request    (request),
      .busACK     (busACK),
      .busDATAI   (busDATAI),
      .busREQ     (busREQ),
      .busADDRO   (busADDRO),
      .grant      (grant),
      .intrVector (intrVector)
   );

endmodule

`default_nettype wire

/* logic/busCycle.sv */
/*
 * Interrupt acknowledge bus cycle
 * Starts a cycle for the pending level while the CPU runs, then runs
 * the four-phase busREQ/busACK handshake. The device's vector word is
 * captured at the acknowledge and the grant pulses once the device has
 * released the bus.
 */

`timescale 1ns/1ps
`default_nettype none

module busCycle (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  cpuRun,      // New cycles allowed
   input  wire ksPkg::intrReqT  request,     // From arbiter
   input  wire                  busACK,      // Bus acknowledge
   input  wire ksPkg::wordT     busDATAI,    // Bus data input
   output logic                 busREQ,      // Bus request
   output ksPkg::busAddrT       busADDRO,    // Bus address and flags
   output ksPkg::grantT         grant,       // Cycle done to arbiter
   output ksPkg::wordT          intrVector   // Captured vector word
);

   ksPkg::cycStateT state;

   //////////////////////////////
   // Handshake FSM

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= ksPkg::idle;
         busADDRO <= '0;
      end else begin
         case (state)
            ksPkg::idle:
               // Wait out a slow release before requesting again
               if (request.pending && cpuRun && !busACK) begin
                  busADDRO.ackCycle <= 1'b1;
                  busADDRO.level    <= request.level;
                  state             <= ksPkg::waitAck;
               end
            ksPkg::waitAck:
               if (busACK)
                  state <= ksPkg::waitRelease;
            ksPkg::waitRelease:
               if (!busACK)
                  state <= ksPkg::finish;
            ksPkg::finish:
               state <= ksPkg::idle;
            default:
               state <= ksPkg::idle;
         endcase
      end
   end

   // Vector word is valid with the acknowledge
   always_ff @(posedge clk) begin
      if (rst)
         intrVector <= '0;
      else if (state == ksPkg::waitAck && busACK)
         intrVector <= busDATAI;
   end

   assign busREQ      = (state == ksPkg::waitAck);
   assign grant.done  = (state == ksPkg::finish);   // One clock only
   assign grant.level = busADDRO.level;

   //////////////////////////////
   // Bus protocol checks

   reqHeldUntilAck: assert property (
      @(posedge clk) disable iff (rst)
      busREQ && !busACK |=> busREQ
   ) else $error("busREQ dropped before busACK");

   addrStableDuringReq: assert property (
      @(posedge clk) disable iff (rst)
      busREQ |=> !busREQ || $stable(busADDRO)
   ) else $error("busADDRO changed while busREQ high");

endmodule

`default_nettype wire

/* logic/intrArbiter.sv */
/*
 * Priority interrupt controller
 * Merges the seven bus lines with the timer request, picks the
 * lowest-numbered active line and holds one level in service from the
 * bus grant until the dismiss input.
 */

`timescale 1ns/1ps
`default_nettype none

module intrArbiter (
   input  wire                    clk,
   input  wire                    rst,
   input  wire ksPkg::intrLinesT  busINTR,      // Bus request lines
   input  wire                    timerINTR,    // Timer request
   input  wire                    intrDismiss,  // End of service
   input  wire ksPkg::grantT      grant,        // Cycle done from bus unit
   output ksPkg::intrReqT         request,      // To bus unit
   output ksPkg::intpT            curINTP       // Level in service
);

   ksPkg::intrLinesT lines;
   ksPkg::intpT      selLevel;

   //////////////////////////////
   // Priority select

   always_comb begin
      lines = busINTR;
      lines[ksPkg::timerLevel] = lines[ksPkg::timerLevel] | timerINTR;
      selLevel = '0;
      // Walk down so level 1 is the last to win
      for (int i = ksPkg::intrLines; i >= 1; i--) begin
         if (lines[i])
            selLevel = ksPkg::intpT'(i);
      end
   end

   //////////////////////////////
   // Registered request

   // Cleared on the grant clock so the old request is never seen twice
   always_ff @(posedge clk) begin
      if (rst) begin
         request <= '0;
      end else begin
         request.pending <= (selLevel != '0) && (curINTP == '0) && !grant.done;
         request.level   <= selLevel;
      end
   end

   // Level in service
   always_ff @(posedge clk) begin
      if (rst)
         curINTP <= '0;
      else if (grant.done)
         curINTP <= grant.level;
      else if (intrDismiss)
         curINTP <= '0;
   end

   // The bus unit must not finish a cycle on top of a level in service
   grantOnlyWhenIdle: assert property (
      @(posedge clk) disable iff (rst)
      grant.done |-> (curINTP == '0)
   ) else $error("grant while level %0d in service", curINTP);

endmodule

`default_nettype wire

/* logic/intervalTimer.sv */
/*
 * Interval timer
 * A prescaler divides the clock by msecTicks while the timer is enabled.
 * Each wrap bumps the 18-bit count and raises the timer interrupt, which
 * stays set until its level is acknowledged on the bus.
 */

`timescale 1ns/1ps
`default_nettype none

module intervalTimer (
   input  wire                clk,
   input  wire                rst,
   input  wire                timerEN,     // Console timer enable
   input  wire ksPkg::grantT  grant,       // Acknowledge from bus unit
   output logic               timerINTR,   // Timer interrupt request
   output ksPkg::timerCountT  timerCOUNT
);

   ksPkg::prescaleT prescale;
   logic            tick;
   logic            timerClr;

   // Prescaler at its last state while enabled
   assign tick = timerEN &&
                 (prescale == ksPkg::prescaleT'(ksPkg::msecTicks - 1));

   assign timerClr = grant.done &&
                     (grant.level == ksPkg::intpT'(ksPkg::timerLevel));

   //////////////////////////////
   // Prescaler and count

   always_ff @(posedge clk) begin
      if (rst) begin
         prescale   <= '0;
         timerCOUNT <= '0;
      end else if (timerEN) begin
         if (tick) begin
            prescale   <= '0;
            timerCOUNT <= timerCOUNT + 1'b1;   // Wraps at full width
         end else begin
            prescale <= prescale + 1'b1;
         end
      end
   end

   // Interrupt flag where a new tick beats the acknowledge
   always_ff @(posedge clk) begin
      if (rst)
         timerINTR <= 1'b0;
      else if (tick)
         timerINTR <= 1'b1;
      else if (timerClr)
         timerINTR <= 1'b0;
   end

endmodule

`default_nettype wire

/* logic/consoleCtl.sv */
/*
 * Console run/halt control
 * The RUN and HALT switches move a two-state machine. HALT wins when
 * both are pressed. cpuHALT and cpuRun are registered with the state.
 */

`timescale 1ns/1ps
`default_nettype none

module consoleCtl (
   input  wire   clk,
   input  wire   rst,
   input  wire   cslRUN,      // Run switch
   input  wire   cslHALT,     // Halt switch
   output logic  cpuRun,      // Bus cycles allowed
   output logic  cpuHALT      // Run/halt status
);

   ksPkg::runStateT state;
   ksPkg::runStateT nextState;

   always_comb begin
      nextState = state;
      if (cslHALT)
         nextState = ksPkg::halted;
      else if (cslRUN)
         nextState = ksPkg::running;
   end

   // Status flops load with the state so they follow the switch next clock
   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= ksPkg::halted;
         cpuRun  <= 1'b0;
         cpuHALT <= 1'b1;
      end else begin
         state   <= nextState;
         cpuRun  <= (nextState == ksPkg::running);
         cpuHALT <= (nextState == ksPkg::halted);
      end
   end

endmodule

`default_nettype wire

/* logic/ksPkg.sv */
/*
 * KS10 support logic shared definitions
 * Word and priority widths, the bus address and interrupt handshake
 * structs, the state machine encodings and the timer constants used by
 * the console, timer, arbiter and bus cycle blocks.
 */

`default_nettype none

package ksPkg;

   //////////////////////////////
   // Widths

   localparam int wordWidth  = 36;          // PDP-10 word
   localparam int intpWidth  = 3;           // Priority 0..7
   localparam int intrLines  = 7;           // Bus lines 1..7
   localparam int timerWidth = 18;          // Timer count

   //////////////////////////////
   // Timer constants

   localparam int msecTicks     = 20;       // Enabled clocks per count
   localparam int timerLevel    = 3;        // Fixed timer priority
   localparam int prescaleWidth = $clog2(msecTicks);

   //////////////////////////////
   // Plain vector types

   typedef logic [wordWidth-1:0]     wordT;
   typedef logic [intpWidth-1:0]     intpT;        // 0 means none, 1 is highest
   typedef logic [intrLines:1]       intrLinesT;   // Bit n requests level n
   typedef logic [timerWidth-1:0]    timerCountT;
   typedef logic [prescaleWidth-1:0] prescaleT;

   //////////////////////////////
   // Structs between blocks

   // Bus address and flags
   typedef struct packed {
      logic ackCycle;                       // Interrupt acknowledge cycle
      intpT level;                          // Level being acknowledged
   } busAddrT;

   // Arbiter to bus unit
   typedef struct packed {
      logic pending;
      intpT level;
   } intrReqT;

   // Bus unit back to arbiter
   typedef struct packed {
      logic done;                           // One clock at end of cycle
      intpT level;
   } grantT;

   // State machines
   typedef enum logic {halted, running} runStateT;
   typedef enum logic [1:0] {idle, waitAck, waitRelease, finish} cycStateT;

endpackage

`default_nettype wire
